/* unary_mac_settings.svh */
`ifndef UNARY_MAC_SETTINGS_SVH
`define UNARY_MAC_SETTINGS_SVH

// operand, lane count and sum width
`define UMAC_DATA_W 8

// number of multiplier lanes, kept a multiple of 4 for the adder tree
`define UMAC_LANES 16

// width of the sobol index and value
`define UMAC_SOBOL_W 8

`endif

/* unary_mac_pkg.sv */
package unary_mac_pkg;

    // per-lane window state
    typedef enum logic {
        LANE_IDLE = 1'b0,
        LANE_RUN  = 1'b1
    } lane_state_e;

    // accumulator phase, done is decoded from ACC_DONE
    typedef enum logic [1:0] {
        ACC_IDLE  = 2'd0,
        ACC_RUN   = 2'd1,
        ACC_DRAIN = 2'd2,
        ACC_DONE  = 2'd3
    } acc_phase_e;

endpackage

/* sobol_rng.sv */
`timescale 1ns/1ps
`include "unary_mac_settings.svh"

module sobol_rng (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     enable,
    input  logic                     restart,
    output logic [`UMAC_SOBOL_W-1:0] sobol
);

    logic [`UMAC_SOBOL_W-1:0] idx;
    logic [`UMAC_SOBOL_W-1:0] dir_vec;  // direction vector for this step
    logic                     zero_found;
    logic [`UMAC_SOBOL_W-1:0] sobol_next;

    // lowest zero bit of the index picks the direction vector;
    // first dimension vectors are single bits counted from the msb down
    always_comb begin
        dir_vec    = '0;
        zero_found = 1'b0;
        for (int c = 0; c < `UMAC_SOBOL_W; c++) begin
            if (!zero_found && !idx[c]) begin
                dir_vec[`UMAC_SOBOL_W-1-c] = 1'b1;
                zero_found                 = 1'b1;
            end
        end
    end

    // index wraps from all ones to zero, sequence restarts at value 0
    assign sobol_next = zero_found ? (sobol ^ dir_vec) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx   <= '0;
            sobol <= '0;
        end else if (restart) begin
            idx   <= '0;  // back to index 0
            sobol <= '0;
        end else if (enable) begin
            idx   <= idx + 1'b1;
            sobol <= sobol_next;
        end
    end

endmodule

/* unary_mul_lane.sv */
`timescale 1ns/1ps
`include "unary_mac_settings.svh"

module unary_mul_lane (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`UMAC_DATA_W-1:0]  a,
    input  logic [`UMAC_DATA_W-1:0]  b,
    input  logic                     load_a,
    input  logic                     load_b,
    input  logic [`UMAC_SOBOL_W-1:0] sobol,
    output logic                     mul_bit,
    output logic                     stop
);

    unary_mac_pkg::lane_state_e state;

    logic [`UMAC_DATA_W-1:0] a_reg;    // rate operand
    logic [`UMAC_DATA_W-1:0] win_cnt;  // cycles left in the window

    always_ff @(posedge clk) begin
        if (load_a) begin
            a_reg <= a;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= unary_mac_pkg::LANE_IDLE;
            win_cnt <= '0;
        end else if (load_b) begin
            win_cnt <= b;
            // a zero-length window never enters run
            state   <= (b != '0) ? unary_mac_pkg::LANE_RUN : unary_mac_pkg::LANE_IDLE;
        end else if (state == unary_mac_pkg::LANE_RUN) begin
            win_cnt <= win_cnt - 1'b1;
            if (win_cnt == 'd1) begin
                state <= unary_mac_pkg::LANE_IDLE;  // last window cycle
            end
        end
    end

    // bitstream rate is a/256, gated to the window
    assign mul_bit = (state == unary_mac_pkg::LANE_RUN) && (a_reg > sobol);

    // counter exhausted
    assign stop = (win_cnt == '0);

endmodule

/* unary_mac.sv */
`timescale 1ns/1ps
`include "unary_mac_settings.svh"

module unary_mac (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`UMAC_DATA_W-1:0] a [`UMAC_LANES-1:0],
    input  logic [`UMAC_DATA_W-1:0] b [`UMAC_LANES-1:0],
    input  logic                    load_a,
    input  logic                    load_b,
    output logic [`UMAC_DATA_W-1:0] sum,
    output logic                    done,
    output logic                    oc
);

    localparam int GROUPS = `UMAC_LANES / 4;

    unary_mac_pkg::acc_phase_e phase;

    logic [`UMAC_SOBOL_W-1:0] sobol_mul;
    logic [`UMAC_SOBOL_W-1:0] sobol_out;
    logic [`UMAC_LANES-1:0]   mul_bit;
    logic [`UMAC_LANES-1:0]   stop;
    logic [`UMAC_DATA_W-1:0]  lane_cnt [`UMAC_LANES-1:0];
    logic [`UMAC_DATA_W-1:0]  part_d [GROUPS-1:0];
    logic [`UMAC_DATA_W-1:0]  part_q [GROUPS-1:0];
    logic [`UMAC_DATA_W-1:0]  sum_d;
    logic                     accept;
    logic                     load_a_ok;
    logic                     load_b_ok;
    logic                     drain_cnt;

    // loads only between jobs
    assign accept    = (phase == unary_mac_pkg::ACC_IDLE) || (phase == unary_mac_pkg::ACC_DONE);
    assign load_a_ok = load_a && accept;
    assign load_b_ok = load_b && accept;

    // lane-side generator restarts with each window
    sobol_rng u_rng_mul (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (1'b1),
        .restart (load_b_ok),
        .sobol   (sobol_mul)
    );

    // output generator is free running
    sobol_rng u_rng_out (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (1'b1),
        .restart (1'b0),
        .sobol   (sobol_out)
    );

    genvar i;
    generate
        for (i = 0; i < `UMAC_LANES; i++) begin : g_lane
            unary_mul_lane u_lane (
                .clk     (clk),
                .rst_n   (rst_n),
                .a       (a[i]),
                .b       (b[i]),
                .load_a  (load_a_ok),
                .load_b  (load_b_ok),
                .sobol   (sobol_mul),
                .mul_bit (mul_bit[i]),
                .stop    (stop[i])
            );

            // ones counter, wraps modulo 256
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    lane_cnt[i] <= '0;
                end else if (load_b_ok) begin
                    lane_cnt[i] <= '0;
                end else begin
                    lane_cnt[i] <= lane_cnt[i] + mul_bit[i];
                end
            end
        end
    endgenerate

    // first tree stage, groups of four lanes
    always_comb begin
        for (int g = 0; g < GROUPS; g++) begin
            part_d[g] = '0;
            for (int j = 0; j < 4; j++) begin
                part_d[g] = part_d[g] + lane_cnt[4*g+j];
            end
        end
    end

    always_comb begin
        sum_d = '0;
        for (int g = 0; g < GROUPS; g++) begin
            sum_d = sum_d + part_q[g];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int g = 0; g < GROUPS; g++) begin
                part_q[g] <= '0;
            end
            sum <= '0;
        end else begin
            part_q <= part_d;
            sum    <= sum_d;  // second stage
        end
    end

    // unary output stream, sum ones per 256 cycles
    assign oc = sum > sobol_out;

    // drain covers the two adder tree registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= unary_mac_pkg::ACC_IDLE;
            drain_cnt <= 1'b0;
        end else if (load_b_ok) begin
            phase <= unary_mac_pkg::ACC_RUN;
        end else begin
            case (phase)
                unary_mac_pkg::ACC_RUN: begin
                    if (&stop) begin
                        phase     <= unary_mac_pkg::ACC_DRAIN;
                        drain_cnt <= 1'b0;
                    end
                end
                unary_mac_pkg::ACC_DRAIN: begin
                    drain_cnt <= 1'b1;
                    if (drain_cnt) begin
                        phase <= unary_mac_pkg::ACC_DONE;
                    end
                end
                default: ;  // idle and done hold until load_b
            endcase
        end
    end

    assign done = (phase == unary_mac_pkg::ACC_DONE);

endmodule

/* unary_mac_assertions.sv */
`timescale 1ns/1ps
`include "unary_mac_settings.svh"

module unary_mac_assertions (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    load_b,
    input logic                    done,
    input logic                    oc,
    input logic [`UMAC_DATA_W-1:0] sum,
    input unary_mac_pkg::acc_phase_e phase,
    input logic [`UMAC_LANES-1:0]  stop
);

    int fail_count = 0;

    a_load_b_idle: assert property (@(posedge clk) disable iff (!rst_n)
        load_b |-> (phase != unary_mac_pkg::ACC_RUN && phase != unary_mac_pkg::ACC_DRAIN))
        else begin
            $error("load_b during an active window");
            fail_count++;
        end

    a_done_stop: assert property (@(posedge clk) disable iff (!rst_n)
        !(&stop) |-> !done)
        else begin
            $error("done high while a lane is still running");
            fail_count++;
        end

    a_oc_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (sum == '0) |-> !oc)
        else begin
            $error("oc high with a zero sum");
            fail_count++;
        end

endmodule

bind unary_mac unary_mac_assertions u_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .load_b (load_b),
    .done   (done),
    .oc     (oc),
    .sum    (sum),
    .phase  (phase),
    .stop   (stop)
);

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps
`include "unary_mac_settings.svh"

module tb_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load_b,
    input  logic                    done,
    input  logic                    oc,
    input  logic [`UMAC_DATA_W-1:0] sum,
    input  logic [`UMAC_DATA_W-1:0] exp_sum,
    input  logic [`UMAC_DATA_W-1:0] max_b,
    input  logic [8*16-1:0]         test_name,
    output int                      n_pass,
    output int                      n_fail,
    output int                      n_checked
);

    logic idle_ok;
    logic seen_load;

    // one job from the load_b edge through 256 cycles of oc
    task automatic check_window();
        int  cyc;
        int  ones;
        logic ok;
        ok   = 1'b1;
        cyc  = 1;
        ones = 0;
        @(posedge clk);
        if (done) begin
            $display("%0s: done still high on the edge after load_b", test_name);
            ok = 1'b0;
        end
        while (!done) begin
            @(posedge clk);
            cyc++;
        end
        // done seen one sample after the edge it rose on
        if (cyc - 1 != int'(max_b) + 3) begin
            $display("ERR %0s done rise edge expected %0d actual %0d", test_name,
                     int'(max_b) + 3, cyc - 1);
            ok = 1'b0;
        end
        if (sum !== exp_sum) begin
            $display("ERR %0s sum expected %02h actual %02h", test_name, exp_sum, sum);
            ok = 1'b0;
        end
        for (int n = 0; n < 256; n++) begin
            if (n > 0) begin
                @(posedge clk);
            end
            if (!done) begin
                $display("%0s: done fell while the output stream was counted", test_name);
                ok = 1'b0;
            end
            ones += int'(oc);
        end
        if (ones != int'(sum)) begin
            $display("ERR %0s oc ones expected %0d actual %0d", test_name, sum, ones);
            ok = 1'b0;
        end
        if (ok) begin
            $display("PASS %0s", test_name);
            n_pass++;
        end else begin
            $display("FAIL %0s", test_name);
            n_fail++;
        end
        n_checked++;
    endtask

    initial begin
        n_pass    = 0;
        n_fail    = 0;
        n_checked = 0;
        idle_ok   = 1'b1;
        seen_load = 1'b0;
        wait (rst_n);
        // outputs must stay quiet until the first job
        while (!seen_load) begin
            @(posedge clk);
            if (load_b) begin
                seen_load = 1'b1;
            end else if (done || sum != '0 || oc) begin
                idle_ok = 1'b0;
            end
        end
        if (idle_ok) begin
            $display("PASS reset_idle");
            n_pass++;
        end else begin
            $display("reset_idle: done, sum or oc was not zero before the first load");
            $display("FAIL reset_idle");
            n_fail++;
        end
        forever begin
            check_window();
            do @(posedge clk); while (!load_b);
        end
    end

endmodule

/* tb_unary_mac.sv */
`timescale 1ns/1ps
`include "unary_mac_settings.svh"

module tb_unary_mac;

    localparam int MAX_PAT = 64;

    logic                    clk;
    logic                    rst_n;
    logic [`UMAC_DATA_W-1:0] a [`UMAC_LANES-1:0];
    logic [`UMAC_DATA_W-1:0] b [`UMAC_LANES-1:0];
    logic                    load_a;
    logic                    load_b;
    logic [`UMAC_DATA_W-1:0] sum;
    logic                    done;
    logic                    oc;

    logic [`UMAC_DATA_W-1:0] pat_a [0:MAX_PAT-1][0:`UMAC_LANES-1];
    logic [`UMAC_DATA_W-1:0] pat_b [0:MAX_PAT-1][0:`UMAC_LANES-1];
    logic [`UMAC_DATA_W-1:0] pat_sum [0:MAX_PAT-1];
    logic [8*16-1:0]         pat_name [0:MAX_PAT-1];

    logic [`UMAC_DATA_W-1:0] exp_sum;
    logic [`UMAC_DATA_W-1:0] max_b;
    logic [8*16-1:0]         cur_name;
    int                      n_pass;
    int                      n_fail;
    int                      n_checked;
    int                      n_pat;
    int                      seed;
    logic                    loaded;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    unary_mac uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .a      (a),
        .b      (b),
        .load_a (load_a),
        .load_b (load_b),
        .sum    (sum),
        .done   (done),
        .oc     (oc)
    );

    tb_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_b    (load_b),
        .done      (done),
        .oc        (oc),
        .sum       (sum),
        .exp_sum   (exp_sum),
        .max_b     (max_b),
        .test_name (cur_name),
        .n_pass    (n_pass),
        .n_fail    (n_fail),
        .n_checked (n_checked)
    );

    // first character of a right-justified token
    function automatic logic [7:0] first_char(input logic [8*16-1:0] tok);
        logic [7:0] c;
        c = 8'h00;
        for (int i = 0; i < 16; i++) begin
            if (tok[8*i+:8] != 8'h00) begin
                c = tok[8*i+:8];
            end
        end
        return c;
    endfunction

    task automatic read_patterns();
        int              fd;
        int              code;
        logic            more;
        logic [8*16-1:0] tok;
        logic [8*128-1:0] rest;
        logic [7:0]      val;
        n_pat = 0;
        more  = 1'b1;
        fd    = $fopen("unary_mac_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open unary_mac_patterns.txt");
        end else begin
            while (more) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    more = 1'b0;
                end else if (first_char(tok) == "#") begin
                    code = $fgets(rest, fd);  // skip comment line
                end else if (n_pat < MAX_PAT) begin
                    pat_name[n_pat] = tok;
                    for (int i = 0; i < `UMAC_LANES; i++) begin
                        code = $fscanf(fd, "%h", val);
                        pat_a[n_pat][i] = val;
                    end
                    for (int i = 0; i < `UMAC_LANES; i++) begin
                        code = $fscanf(fd, "%h", val);
                        pat_b[n_pat][i] = val;
                    end
                    code = $fscanf(fd, "%h", val);
                    pat_sum[n_pat] = val;
                    n_pat++;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int limit;
        wait (loaded);
        limit = n_pat * (256 + 256 + 20) + 50;
        repeat (limit) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", limit);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int gap;
        int total_fail;
        logic [`UMAC_DATA_W-1:0] mb;
        for (int i = 0; i < `UMAC_LANES; i++) begin
            a[i] = '0;
            b[i] = '0;
        end
        load_a   = 1'b0;
        load_b   = 1'b0;
        exp_sum  = '0;
        max_b    = '0;
        cur_name = '0;
        seed     = 58828;
        loaded   = 1'b0;
        read_patterns();
        loaded = 1'b1;
        wait (rst_n);
        repeat (10) @(posedge clk);  // idle window for the reset check
        for (int p = 0; p < n_pat; p++) begin
            gap = $random(seed) & 32'h7;
            repeat (gap) @(posedge clk);
            mb = '0;
            for (int i = 0; i < `UMAC_LANES; i++) begin
                if (pat_b[p][i] > mb) begin
                    mb = pat_b[p][i];
                end
            end
            @(posedge clk);
            exp_sum  <= pat_sum[p];
            max_b    <= mb;
            cur_name <= pat_name[p];
            for (int i = 0; i < `UMAC_LANES; i++) begin
                a[i] <= pat_a[p][i];
            end
            load_a <= 1'b1;
            @(posedge clk);
            load_a <= 1'b0;
            for (int i = 0; i < `UMAC_LANES; i++) begin
                b[i] <= pat_b[p][i];
            end
            load_b <= 1'b1;
            @(posedge clk);
            load_b <= 1'b0;
            while (n_checked < p + 1) begin
                @(posedge clk);
            end
        end
        total_fail = n_fail + uut.u_assert.fail_count;
        $display("summary: %0d passed, %0d failed, %0d assertion failures", n_pass, n_fail,
                 uut.u_assert.fail_count);
        if (total_fail == 0 && n_pat > 0 && n_pass == n_pat + 1) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* unary_mac_patterns.txt */
# name, 16 A values from lane 0, 16 B values from lane 0, expected sum, all hex
# sum is the total of lane counts mod 256, lane count = sobol values below A in the first B
t00 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
t01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 00
t02 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff e0
t03 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 00
t04 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 10
t05 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
t06 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 10
t07 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 20
t08 81 81 81 81 81 81 81 81 81 81 81 81 81 81 81 81 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 20
t09 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 10
t10 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 c0 04 04 04 04 04 04 04 04 04 04 04 04 04 04 04 04 30
t11 c1 c1 c1 c1 c1 c1 c1 c1 c1 c1 c1 c1 c1 c1 c1 c1 04 04 04 04 04 04 04 04 04 04 04 04 04 04 04 04 40
t12 03 03 03 03 03 03 03 03 03 03 03 03 03 03 03 03 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 20
t13 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 10
t14 00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 c0
t15 00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 71
t16 00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 04 04 04 04 04 04 04 04 04 04 04 04 04 04 04 04 24
t17 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 88
t18 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 0a 1a 2a 3a 4a 5a 6a 7a 8a 9a aa ba ca da ea fa 1b
t19 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff aa aa aa aa aa aa aa aa aa aa aa aa aa aa aa aa a0
t20 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ab ab ab ab ab ab ab ab ab ab ab ab ab ab ab ab a0
t21 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff a9 a9 a9 a9 a9 a9 a9 a9 a9 a9 a9 a9 a9 a9 a9 a9 90
t22 ff 00 ff 00 ff 00 ff 00 ff 00 ff 00 ff 00 ff 00 05 ff 05 ff 05 ff 05 ff 05 ff 05 ff 05 ff 05 ff 28
t23 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 0f
t24 ff ff ff ff ff ff ff ff 00 00 00 00 00 00 00 00 ff ff ff ff ff ff ff ff 00 00 00 00 00 00 00 00 f0
t25 00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 e0
t26 01 11 21 31 41 51 61 71 81 91 a1 b1 c1 d1 e1 f1 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 d0
t27 01 11 21 31 41 51 61 71 81 91 a1 b1 c1 d1 e1 f1 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 81
t28 01 11 21 31 41 51 61 71 81 91 a1 b1 c1 d1 e1 f1 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 10
t29 00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 0f
t30 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 40
t31 41 41 41 41 41 41 41 41 41 41 41 41 41 41 41 41 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 50
t32 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01 01
t33 ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 80 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 80
t34 ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 fe
t35 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 40
t36 21 21 21 21 21 21 21 21 21 21 21 21 21 21 21 21 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 50
t37 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff c8 c8 c8 c8 c8 c8 c8 c8 c8 c8 c8 c8 c8 c8 c8 c8 70
t38 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 02 10
t39 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 03 03 03 03 03 03 03 03 03 03 03 03 03 03 03 03 30
t40 e0 e0 e0 e0 e0 e0 e0 e0 e0 e0 e0 e0 e0 e0 e0 e0 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 70
t41 e1 e1 e1 e1 e1 e1 e1 e1 e1 e1 e1 e1 e1 e1 e1 e1 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 08 80
t42 00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 78
t43 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00

/* tb.f */
+incdir+.
unary_mac_pkg.sv
sobol_rng.sv
unary_mul_lane.sv
unary_mac.sv
unary_mac_assertions.sv
tb_clk_gen.sv
tb_checker.sv
tb_unary_mac.sv

/* Makefile */
# Verilator build and run for the unary MAC testbench

TOP      ?= tb_unary_mac
FLIST    ?= tb.f
SRCS     ?= unary_mac_pkg.sv sobol_rng.sv unary_mul_lane.sv unary_mac.sv \
            unary_mac_assertions.sv tb_clk_gen.sv tb_checker.sv tb_unary_mac.sv
HDRS     ?= unary_mac_settings.svh
VERILATOR ?= verilator
VFLAGS   ?= --binary --timing --assert
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
RUN_ARGS ?= +verilator+error+limit+1000

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FLIST) -o V$(TOP)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "All tests passed!" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
